//--- verilog.f
verilog/core_pkg.sv
verilog/apb_config_regs.sv
verilog/instr_fetch.sv
verilog/reg_file.sv
verilog/instr_decode.sv
verilog/alu_execute.sv
verilog/mini_core_top.sv
sim/mini_core_tb.sv

//--- sim/mini_core_tb.sv
/*
 * Testbench for the mini RV32I core.
 * Loads random ALU programs over APB, runs them and compares
 * every architectural register with an in-order model.
 */
`default_nettype none

module mini_core_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int IMEM_AW      = 4;
    localparam int PROG_LEN     = 2**IMEM_AW;
    localparam int NUM_PROGRAMS = 20;
    localparam int MAX_POLLS    = 40;
    localparam int NUM_REGS     = 32;
    // Every run costs loads, polls and register reads, two cycles per access.
    localparam int NUM_RUNS     = NUM_PROGRAMS + 6;
    localparam int RUN_CYCLES   = 2 * (PROG_LEN + 3 + MAX_POLLS + NUM_REGS);
    localparam int WATCHDOG_NS  = (NUM_RUNS * RUN_CYCLES + 500) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] lcg_state;
    logic [31:0] model_regs [NUM_REGS];
    logic [31:0] prog [PROG_LEN];
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          errors_at_start;

    mini_core_top #(
        .IMEM_ADDR_W ( IMEM_AW )
    ) mini_core_top_i (
        .i_clk   ( clk     ),
        .i_rst_n ( rst_n   ),
        .i_apb   ( apb_req ),
        .o_apb   ( apb_rsp )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------------------------------------
    // Random programs.
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        r   = next_rand();
        // Registers x0 to x7 only, so dependencies are dense.
        rd  = 5'(r[2:0]);
        rs1 = 5'(r[5:3]);
        rs2 = 5'(r[8:6]);
        case (r[31:28])
            4'd0:        return {r[31:7], 7'b0000011};
            4'd1, 4'd2:  return r_type(7'h00, 3'h0, rd, rs1, rs2);
            4'd3, 4'd4:  return r_type(7'h20, 3'h0, rd, rs1, rs2);
            4'd5:        return r_type(7'h00, 3'h7, rd, rs1, rs2);
            4'd6:        return r_type(7'h00, 3'h6, rd, rs1, rs2);
            4'd7, 4'd8:  return r_type(7'h00, 3'h4, rd, rs1, rs2);
            4'd9, 4'd10: return r_type(7'h00, 3'h2, rd, rs1, rs2);
            default:     return addi_instr(rd, rs1, r[27:16]);
        endcase
    endfunction

    // ------------------------------------------------------------
    // Architectural model.
    // ------------------------------------------------------------
    task automatic execute_instr(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        writes;
        a      = model_regs[instr[19:15]];
        b      = model_regs[instr[24:20]];
        imm    = {{20{instr[31]}}, instr[31:20]};
        writes = 1'b1;
        res    = '0;
        if (instr[6:0] == 7'b0010011 && instr[14:12] == 3'b000) begin
            res = a + imm;
        end else if (instr[6:0] == 7'b0110011) begin
            case ({instr[31:25], instr[14:12]})
                {7'h00, 3'h0}: res = a + b;
                {7'h20, 3'h0}: res = a - b;
                {7'h00, 3'h7}: res = a & b;
                {7'h00, 3'h6}: res = a | b;
                {7'h00, 3'h4}: res = a ^ b;
                {7'h00, 3'h2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:       writes = 1'b0;
            endcase
        end else begin
            writes = 1'b0;
        end
        // x0 is never written.
        if (writes && instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;
        end
    endtask

    task automatic run_model(input int len);
        for (int i = 0; i < len; i++) begin
            execute_instr(prog[i]);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------
    // APB driver. Called 2 ns after a rising edge.
    // ------------------------------------------------------------
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(negedge clk);
        // Every access completes in its access phase.
        check_value("pready", 32'(apb_rsp.pready), 32'd1);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        check_value($sformatf("pslverr on write 0x%02h", addr), 32'(slverr), 32'(exp_err));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic slverr;
        apb_access(1'b0, addr, 32'd0, data, slverr);
        check_value($sformatf("pslverr on read 0x%02h", addr), 32'(slverr), 32'(exp_err));
    endtask

    task automatic check_all_regs();
        logic [31:0] value;
        for (int i = 0; i < NUM_REGS; i++) begin
            apb_read(REG_BASE + 8'(4 * i), value, 1'b0);
            check_value($sformatf("x%0d", i), value, model_regs[i]);
        end
    endtask

    task automatic load_program(input int len);
        for (int i = 0; i < PROG_LEN; i++) begin
            apb_write(IMEM_BASE + 8'(4 * i), prog[i], 1'b0);
        end
        apb_write(ADDR_LEN, 32'(len), 1'b0);
    endtask

    task automatic start_run();
        apb_write(ADDR_CTRL, 32'd1, 1'b0);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            apb_read(ADDR_STATUS, status, 1'b0);
            polls++;
        end while (status[0] && polls < MAX_POLLS);
        if (status[0]) begin
            $display("Run still busy after %0d status polls", MAX_POLLS);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed", test_count, name);
        end
        errors_at_start = error_count;
    endtask

    // ------------------------------------------------------------
    // Test sequence.
    // ------------------------------------------------------------
    initial begin
        logic [31:0] value;
        lcg_state       = 32'd81;
        error_count     = 0;
        test_count      = 0;
        failed_tests    = 0;
        errors_at_start = 0;
        apb_req         = '0;
        rst_n           = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        apb_read(ADDR_STATUS, value, 1'b0);
        check_value("STATUS", value, 32'd0);
        apb_read(ADDR_LEN, value, 1'b0);
        check_value("LEN", value, 32'd0);
        check_all_regs();
        end_test("reset state");

        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog[i] = random_instr();
            end
            load_program(PROG_LEN);
            start_run();
            wait_idle();
            run_model(PROG_LEN);
            check_all_regs();
        end
        end_test("random programs");

        // Writes to x0 followed straight away by readers of x0.
        prog[0] = addi_instr(5'd1, 5'd0, 12'h055);
        prog[1] = addi_instr(5'd0, 5'd1, 12'h123);
        prog[2] = r_type(7'h00, 3'h0, 5'd0, 5'd1, 5'd1);
        prog[3] = r_type(7'h00, 3'h0, 5'd2, 5'd0, 5'd1);
        prog[4] = r_type(7'h20, 3'h0, 5'd3, 5'd0, 5'd1);
        prog[5] = r_type(7'h00, 3'h6, 5'd4, 5'd0, 5'd0);
        load_program(6);
        start_run();
        wait_idle();
        run_model(6);
        apb_read(REG_BASE, value, 1'b0);
        check_value("x0", value, 32'd0);
        check_all_regs();
        end_test("x0 target");

        prog[0] = addi_instr(5'd5, 5'd0, 12'h03A);
        prog[1] = {12'h7FF, 5'd5, 3'b000, 5'd5, 7'b0000011};
        prog[2] = r_type(7'h01, 3'h0, 5'd5, 5'd5, 5'd5);
        prog[3] = {12'h5A5, 5'd6, 3'b111, 5'd6, 7'b1111111};
        prog[4] = r_type(7'h00, 3'h0, 5'd7, 5'd5, 5'd6);
        load_program(5);
        start_run();
        wait_idle();
        run_model(5);
        check_all_regs();
        end_test("unknown opcode");

        apb_read(8'h0C, value, 1'b1);
        check_value("unmapped prdata", value, 32'd0);
        apb_write(8'h0C, 32'hFFFF_FFFF, 1'b1);
        apb_write(ADDR_STATUS, 32'd1, 1'b1);
        apb_write(8'h42, 32'hFFFF_FFFF, 1'b1);
        apb_write(REG_BASE + 8'd4, 32'hDEAD_BEEF, 1'b1);
        apb_read(ADDR_STATUS, value, 1'b0);
        check_value("STATUS", value, 32'd0);
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = random_instr();
        end
        load_program(PROG_LEN);
        start_run();
        // Both writes land while the run is busy.
        apb_write(IMEM_BASE, ~prog[0], 1'b1);
        apb_write(ADDR_LEN, 32'd3, 1'b1);
        wait_idle();
        run_model(PROG_LEN);
        apb_read(ADDR_LEN, value, 1'b0);
        check_value("LEN", value, 32'(PROG_LEN));
        start_run();
        wait_idle();
        run_model(PROG_LEN);
        check_all_regs();
        end_test("error responses");

        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = random_instr();
        end
        load_program(9);
        start_run();
        start_run();
        wait_idle();
        run_model(9);
        check_all_regs();
        end_test("short reload");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mini_core_top.sv
/*
 * Mini RV32I core top level.
 * APB configuration block beside a fetch, decode, execute
 * and write-back pipeline with a shared register file.
 */
`default_nettype none

module mini_core_top
    import core_pkg::*;
#(
    parameter int IMEM_ADDR_W = core_pkg::IMEM_ADDR_W
) (
    input  wire logic     i_clk,
    input  wire logic     i_rst_n,
    input  wire apb_req_t i_apb,
    output apb_rsp_t      o_apb
);

    // ----------------------------------------------------------
    // Internal nets.
    // ----------------------------------------------------------
    imem_wr_t              imem_wr;
    logic                  start;
    logic [LEN_W-1:0]      len;
    logic [REG_ADDR_W-1:0] reg_raddr;
    logic [XLEN-1:0]       reg_rdata;
    logic                  last_retired;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    fd_t                   fd;
    de_t                   de;
    wb_t                   wb;

    apb_config_regs #(
        .IMEM_ADDR_W ( IMEM_ADDR_W )
    ) apb_config_regs_i (
        .i_clk          ( i_clk        ),
        .i_rst_n        ( i_rst_n      ),
        .i_apb          ( i_apb        ),
        .i_reg_rdata    ( reg_rdata    ),
        .i_last_retired ( last_retired ),
        .o_apb          ( o_apb        ),
        .o_imem_wr      ( imem_wr      ),
        .o_start        ( start        ),
        .o_len          ( len          ),
        .o_reg_raddr    ( reg_raddr    )
    );

    instr_fetch #(
        .IMEM_ADDR_W ( IMEM_ADDR_W )
    ) instr_fetch_i (
        .i_clk     ( i_clk   ),
        .i_rst_n   ( i_rst_n ),
        .i_imem_wr ( imem_wr ),
        .i_start   ( start   ),
        .i_len     ( len     ),
        .o_fd      ( fd      )
    );

    reg_file reg_file_i (
        .i_clk      ( i_clk     ),
        .i_rst_n    ( i_rst_n   ),
        .i_rs1      ( rs1       ),
        .i_rs2      ( rs2       ),
        .i_dbg_addr ( reg_raddr ),
        .i_wb       ( wb        ),
        .o_rs1_data ( rs1_data  ),
        .o_rs2_data ( rs2_data  ),
        .o_dbg_data ( reg_rdata )
    );

    instr_decode instr_decode_i (
        .i_clk      ( i_clk    ),
        .i_rst_n    ( i_rst_n  ),
        .i_fd       ( fd       ),
        .i_rs1_data ( rs1_data ),
        .i_rs2_data ( rs2_data ),
        .o_rs1      ( rs1      ),
        .o_rs2      ( rs2      ),
        .o_de       ( de       )
    );

    alu_execute alu_execute_i (
        .i_clk          ( i_clk        ),
        .i_rst_n        ( i_rst_n      ),
        .i_de           ( de           ),
        .o_wb           ( wb           ),
        .o_last_retired ( last_retired )
    );

endmodule

`default_nettype wire

//--- verilog/alu_execute.sv
/*
 * Execute stage.
 * Forwards the write-back result into the operands, runs the ALU
 * and registers the execute-to-write-back item.
 */
`default_nettype none

module alu_execute
    import core_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire de_t  i_de,
    output wb_t       o_wb,
    output logic      o_last_retired
);

    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    wb_t             wb_d;

    // ----------------------------------------------------------
    // Forwarding from the write-back register.
    // ----------------------------------------------------------
    assign fwd_a = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_de.rs1);
    assign fwd_b = o_wb.valid && (o_wb.rd != '0) && (o_wb.rd == i_de.rs2)
                   && !i_de.b_is_imm;

    assign op_a = fwd_a ? o_wb.result : i_de.a;
    assign op_b = fwd_b ? o_wb.result : i_de.b;

    always_comb begin
        case (i_de.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = XLEN'($signed(op_a) < $signed(op_b));
            default: result = '0;
        endcase
    end

    assign wb_d = '{valid:  i_de.valid,
                    last:   i_de.valid && i_de.last,
                    rd:     i_de.rd,
                    result: result};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb.valid <= 1'b0;
            o_wb.last  <= 1'b0;
        end else begin
            o_wb <= wb_d;
        end
    end

    // High while the final item of a run sits in write-back.
    assign o_last_retired = o_wb.valid && o_wb.last;

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
/*
 * Decode stage.
 * Turns the fetched word into an ALU operation with operands
 * and registers the decode-to-execute item.
 */
`default_nettype none

module instr_decode
    import core_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire fd_t                   i_fd,
    input  wire logic [XLEN-1:0]       i_rs1_data,
    input  wire logic [XLEN-1:0]       i_rs2_data,
    output logic [REG_ADDR_W-1:0]      o_rs1,
    output logic [REG_ADDR_W-1:0]      o_rs2,
    output de_t                        o_de
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm;
    de_t             de_d;

    assign opcode = opcode_e'(i_fd.instr[6:0]);
    assign funct3 = i_fd.instr[14:12];
    assign funct7 = i_fd.instr[31:25];
    assign imm    = {{(XLEN-12){i_fd.instr[31]}}, i_fd.instr[31:20]};
    assign o_rs1  = i_fd.instr[19:15];
    assign o_rs2  = i_fd.instr[24:20];

    always_comb begin
        de_d.valid    = i_fd.valid;
        de_d.last     = i_fd.last;
        de_d.rs1      = o_rs1;
        de_d.rs2      = o_rs2;
        de_d.a        = i_rs1_data;
        de_d.b        = i_rs2_data;
        de_d.b_is_imm = 1'b0;
        de_d.alu_op   = ALU_NOP;
        case (opcode)
            OP_REG: begin
                if (funct7 == 7'h00) begin
                    case (funct3)
                        3'h0:    de_d.alu_op = ALU_ADD;
                        3'h2:    de_d.alu_op = ALU_SLT;
                        3'h4:    de_d.alu_op = ALU_XOR;
                        3'h6:    de_d.alu_op = ALU_OR;
                        3'h7:    de_d.alu_op = ALU_AND;
                        default: de_d.alu_op = ALU_NOP;
                    endcase
                end else if (funct7 == 7'h20 && funct3 == 3'h0) begin
                    de_d.alu_op = ALU_SUB;
                end
            end
            OP_IMM: begin
                // ADDI is the only immediate form.
                if (funct3 == 3'h0) begin
                    de_d.alu_op   = ALU_ADD;
                    de_d.b        = imm;
                    de_d.b_is_imm = 1'b1;
                end
            end
            default: de_d.alu_op = ALU_NOP;
        endcase
        // A NOP targets x0 so it never writes or forwards.
        de_d.rd = (de_d.alu_op == ALU_NOP) ? '0 : i_fd.instr[11:7];
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_de.valid <= 1'b0;
            o_de.last  <= 1'b0;
        end else begin
            o_de <= de_d;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
/*
 * Architectural register file, 32 x 32 bits.
 * Two pipeline read ports and one debug port, all write-through.
 */
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic [REG_ADDR_W-1:0] i_rs1,
    input  wire logic [REG_ADDR_W-1:0] i_rs2,
    input  wire logic [REG_ADDR_W-1:0] i_dbg_addr,
    input  wire wb_t                   i_wb,
    output logic [XLEN-1:0]            o_rs1_data,
    output logic [XLEN-1:0]            o_rs2_data,
    output logic [XLEN-1:0]            o_dbg_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            we;

    // x0 is never written.
    assign we = i_wb.valid && (i_wb.rd != '0);

    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && addr == i_wb.rd) begin
            value = i_wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
        o_dbg_data = read_port(i_dbg_addr);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[i_wb.rd] <= i_wb.result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instr_fetch.sv
/*
 * Instruction fetch.
 * Instruction memory plus program counter; issues one word
 * per cycle from index 0 up to the programmed length.
 */
`default_nettype none

module instr_fetch
    import core_pkg::*;
#(
    parameter int IMEM_ADDR_W = core_pkg::IMEM_ADDR_W
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire imem_wr_t         i_imem_wr,
    input  wire logic             i_start,
    input  wire logic [LEN_W-1:0] i_len,
    output fd_t                   o_fd
);

    logic [XLEN-1:0]  imem [2**IMEM_ADDR_W];
    logic [LEN_W-1:0] pc;
    logic             active;
    logic             issue;
    logic             last_item;

    always_ff @(posedge i_clk) begin
        if (i_imem_wr.en) begin
            imem[IMEM_ADDR_W'(i_imem_wr.addr)] <= i_imem_wr.data;
        end
    end

    assign issue     = active && (pc < i_len);
    assign last_item = (pc == i_len - 1'b1);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc         <= '0;
            active     <= 1'b0;
            o_fd.valid <= 1'b0;
            o_fd.last  <= 1'b0;
        end else begin
            o_fd.valid <= issue;
            o_fd.last  <= issue && last_item;
            o_fd.instr <= imem[IMEM_ADDR_W'(pc)];
            if (i_start) begin
                pc     <= '0;
                active <= 1'b1;
            end else begin
                if (issue) begin
                    pc <= pc + 1'b1;
                end
                // Stop once the final word has gone out.
                if (!issue || last_item) begin
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/apb_config_regs.sv
/*
 * APB configuration block.
 * Holds the length and busy state, raises the run start pulse,
 * and maps windows onto instruction memory and the register file.
 */
`default_nettype none

module apb_config_regs
    import core_pkg::*;
#(
    parameter int IMEM_ADDR_W = core_pkg::IMEM_ADDR_W
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire apb_req_t              i_apb,
    input  wire logic [XLEN-1:0]       i_reg_rdata,
    input  wire logic                  i_last_retired,
    output apb_rsp_t                   o_apb,
    output imem_wr_t                   o_imem_wr,
    output logic                       o_start,
    output logic [LEN_W-1:0]           o_len,
    output logic [REG_ADDR_W-1:0]      o_reg_raddr
);

    logic             access;
    logic             aligned;
    logic             ctrl_hit;
    logic             len_hit;
    logic             status_hit;
    logic             imem_hit;
    logic             reg_hit;
    logic [3:0]       imem_word;
    logic             imem_in_range;
    logic             err;
    logic             wr_ok;
    logic             busy;
    logic             start_d;
    logic [LEN_W-1:0] len_q;
    logic [XLEN-1:0]  rdata;

    // ----------------------------------------------------------
    // Address decode.
    // ----------------------------------------------------------
    assign access     = i_apb.psel && i_apb.penable;
    assign aligned    = (i_apb.paddr[1:0] == 2'b00);
    assign ctrl_hit   = (i_apb.paddr == ADDR_CTRL);
    assign len_hit    = (i_apb.paddr == ADDR_LEN);
    assign status_hit = (i_apb.paddr == ADDR_STATUS);

    // Only the words that exist in instruction memory are mapped.
    assign imem_word     = i_apb.paddr[5:2];
    assign imem_in_range = (int'(imem_word) < (1 << IMEM_ADDR_W));
    assign imem_hit      = aligned && (i_apb.paddr >= IMEM_BASE) && (i_apb.paddr < REG_BASE)
                           && imem_in_range;
    assign reg_hit       = aligned && (i_apb.paddr >= REG_BASE);

    assign err = access && (!aligned
                 || !(ctrl_hit || len_hit || status_hit || imem_hit || reg_hit)
                 || (i_apb.pwrite && (status_hit || reg_hit))
                 || (i_apb.pwrite && busy && (len_hit || imem_hit)));

    assign wr_ok = access && i_apb.pwrite && !err;

    // Start is dropped while a run is in progress.
    assign o_start = wr_ok && ctrl_hit && i_apb.pwdata[0] && !busy;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy    <= 1'b0;
            start_d <= 1'b0;
            len_q   <= '0;
        end else begin
            start_d <= o_start;
            if (wr_ok && len_hit) begin
                len_q <= i_apb.pwdata[LEN_W-1:0];
            end
            if (o_start) begin
                busy <= 1'b1;
            end else if (i_last_retired || (start_d && len_q == '0)) begin
                // Empty program finishes one cycle after start.
                busy <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Read data and outputs.
    // ----------------------------------------------------------
    assign rdata = (!access || i_apb.pwrite || err) ? '0 :
                   status_hit                       ? XLEN'(busy) :
                   len_hit                          ? XLEN'(len_q) :
                   reg_hit                          ? i_reg_rdata : '0;

    assign o_apb       = '{prdata: rdata, pready: 1'b1, pslverr: err};
    assign o_imem_wr   = '{en:   wr_ok && imem_hit,
                           addr: i_apb.paddr[2 +: core_pkg::IMEM_ADDR_W],
                           data: i_apb.pwdata};
    assign o_len       = len_q;
    assign o_reg_raddr = i_apb.paddr[2 +: REG_ADDR_W];

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
/*
 * Shared definitions for the mini RV32I core.
 * Widths, the APB address map, opcode and ALU enums,
 * and the structs carried between pipeline stages.
 */
`default_nettype none

package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_ADDR_W = 4;
    localparam int APB_ADDR_W  = 8;
    localparam int LEN_W       = 5;

    // ----------------------------------------------------------
    // APB byte address map.
    // ----------------------------------------------------------
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ADDR_LEN    = 8'h04;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 8'h08;
    localparam logic [APB_ADDR_W-1:0] IMEM_BASE   = 8'h40;
    localparam logic [APB_ADDR_W-1:0] REG_BASE    = 8'h80;

    // RV32I major opcodes kept in this core.
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_NOP
    } alu_op_e;

    // ----------------------------------------------------------
    // Bus and stage structs.
    // ----------------------------------------------------------
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [XLEN-1:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] prdata;
        logic            pready;
        logic            pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [IMEM_ADDR_W-1:0] addr;
        logic [XLEN-1:0]        data;
    } imem_wr_t;

    typedef struct packed {
        logic            valid;
        logic            last;
        logic [XLEN-1:0] instr;
    } fd_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic                  b_is_imm;
    } de_t;

    typedef struct packed {
        logic                  valid;
        logic                  last;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
    } wb_t;

endpackage

`default_nettype wire
